/* Makefile */
# cache testbench on verilator

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module cache_tb -f files.f
	-./obj_dir/Vcache_tb +verilator+error+limit+100 > sim.log 2>&1
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" sim.log || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* files.f */
+incdir+include
hw/cache_pkg.sv
hw/cpu_req_gen.sv
hw/cache_ctrl.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/mem_slave.sv
hw/cache_top.sv
tests/cache_checker.sv
tests/cache_tb.sv

/* hw/cache_ctrl.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  logic    cpu_intf,
    input  logic    rst_n,
    input  addr_t   haddr,
    input  htrans_e htrans,
    input  logic    hit,
    input  logic    mem_beat_valid,
    output logic    hready,
    output logic    hit_flag,
    output logic    mem_req,
    output addr_t   mem_addr,
    output logic    dwrite_en,
    output offset_t dwrite_offset,
    output logic    twrite_en
);

    localparam int LINE_BYTES = `WORDS_PER_LINE * (`DATA_W / 8);

    ctrl_state_e state;
    ctrl_state_e state_next;
    addr_t       addr_q;
    offset_t     beat_cnt;
    logic        filling;

    // *****************************************************************
    // next state
    // *****************************************************************
    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (htrans == NONSEQ)
                    state_next = S_LOOKUP;
            end
            S_LOOKUP: begin
                state_next = hit ? S_RESPOND : S_FILL;
            end
            S_FILL: begin
                if (mem_beat_valid && beat_cnt == offset_t'(`WORDS_PER_LINE - 2))
                    state_next = S_FILL_LAST;
            end
            S_FILL_LAST: begin
                if (mem_beat_valid)
                    state_next = S_RESPOND;
            end
            S_RESPOND: begin
                state_next = S_IDLE;
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            mem_req  <= 1'b0;
            hit_flag <= 1'b0;
            beat_cnt <= '0;
        end else begin
            state   <= state_next;
            mem_req <= (state == S_LOOKUP) && !hit;  // one cycle fill request
            if (state == S_LOOKUP) begin
                hit_flag <= hit;
                beat_cnt <= '0;
            end else if (filling && mem_beat_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (state == S_IDLE && htrans == NONSEQ)
            addr_q <= haddr;
    end

    assign filling       = (state == S_FILL) || (state == S_FILL_LAST);
    assign hready        = (state == S_RESPOND);
    assign mem_addr      = addr_q & ~addr_t'(LINE_BYTES - 1);  // line base
    assign dwrite_en     = filling && mem_beat_valid;
    assign dwrite_offset = beat_cnt;
    assign twrite_en     = (state == S_FILL_LAST) && mem_beat_valid;  // tag with last beat

endmodule

/* hw/cache_data_store.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_data_store
    import cache_pkg::*;
(
    input  logic    cpu_intf,
    input  addr_t   addr,
    input  logic    dwrite_en,
    input  offset_t dwrite_offset,
    input  data_t   wdata,
    output data_t   rdata
);

    localparam int DEPTH = `LINES * `WORDS_PER_LINE;
    localparam int WI_W  = $clog2(DEPTH);

    data_t            words [DEPTH];
    index_t           line_idx;
    logic [WI_W-1:0]  wr_idx;
    logic [WI_W-1:0]  rd_idx;

    assign line_idx = addr[IDX_LSB +: $bits(index_t)];
    assign wr_idx   = {line_idx, dwrite_offset};   // fill walks the line
    assign rd_idx   = addr[OFF_LSB +: WI_W];

    always_ff @(posedge cpu_intf) begin
        if (dwrite_en)
            words[wr_idx] <= wdata;
    end

    assign rdata = words[rd_idx];

endmodule

/* hw/cache_pkg.sv */
`include "cache_defs.svh"

package cache_pkg;

    // address field positions
    localparam int OFF_LSB = $clog2(`DATA_W / 8);
    localparam int IDX_LSB = OFF_LSB + $clog2(`WORDS_PER_LINE);
    localparam int TAG_LSB = IDX_LSB + $clog2(`LINES);

    typedef logic [`ADDR_W-1:0]                 addr_t;
    typedef logic [`DATA_W-1:0]                 data_t;
    typedef logic [`ADDR_W-TAG_LSB-1:0]         tag_t;
    typedef logic [$clog2(`LINES)-1:0]          index_t;
    typedef logic [$clog2(`WORDS_PER_LINE)-1:0] offset_t;
    typedef logic [15:0]                        count_t;

    // ahb transfer type without busy
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR4  = 3'b011
    } hburst_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL,
        S_FILL_LAST,
        S_RESPOND
    } ctrl_state_e;

endpackage

/* hw/cache_tag_store.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_tag_store
    import cache_pkg::*;
(
    input  logic  cpu_intf,
    input  logic  rst_n,
    input  addr_t lookup_addr,
    input  logic  twrite_en,
    output logic  hit
);

    index_t             idx;
    tag_t               addr_tag;
    tag_t               tags [`LINES];
    logic [`LINES-1:0]  valid;

    assign idx      = lookup_addr[IDX_LSB +: $bits(index_t)];
    assign addr_tag = lookup_addr[TAG_LSB +: $bits(tag_t)];

    always_ff @(posedge cpu_intf) begin
        if (!rst_n)
            valid <= '0;
        else if (twrite_en)
            valid[idx] <= 1'b1;
    end

    always_ff @(posedge cpu_intf) begin
        if (twrite_en)
            tags[idx] <= addr_tag;
    end

    // direct mapped, single compare
    assign hit = valid[idx] && (tags[idx] == addr_tag);

endmodule

/* hw/cache_top.sv */
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
(
    input  logic       cpu_intf,
    input  logic       rst_n,
    input  logic       run,
    input  logic [7:0] seed,
    input  count_t     period,
    input  count_t     req_count,
    input  logic       load_en,
    input  addr_t      load_addr,
    input  data_t      load_data,
    output logic       rsp_valid,
    output addr_t      rsp_addr,
    output data_t      rsp_data,
    output logic       rsp_hit,
    output logic       done
);

    // cpu side bus
    addr_t   haddr;
    htrans_e htrans;
    hburst_e hburst;
    logic    hready;
    data_t   hrdata;

    logic    hit;
    logic    hit_flag;
    logic    twrite_en;
    logic    dwrite_en;
    offset_t dwrite_offset;

    // memory side
    logic    mem_req;
    addr_t   mem_addr;
    logic    mem_beat_valid;
    data_t   mem_rdata;

    cpu_req_gen u_gen (
        .cpu_intf  (cpu_intf),
        .rst_n     (rst_n),
        .run       (run),
        .seed      (seed),
        .period    (period),
        .req_count (req_count),
        .hready    (hready),
        .haddr     (haddr),
        .htrans    (htrans),
        .hburst    (hburst),
        .done      (done)
    );

    cache_ctrl u_ctrl (
        .cpu_intf       (cpu_intf),
        .rst_n          (rst_n),
        .haddr          (haddr),
        .htrans         (htrans),
        .hit            (hit),
        .mem_beat_valid (mem_beat_valid),
        .hready         (hready),
        .hit_flag       (hit_flag),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .dwrite_en      (dwrite_en),
        .dwrite_offset  (dwrite_offset),
        .twrite_en      (twrite_en)
    );

    cache_tag_store u_tags (
        .cpu_intf    (cpu_intf),
        .rst_n       (rst_n),
        .lookup_addr (haddr),       // held by the generator until hready
        .twrite_en   (twrite_en),
        .hit         (hit)
    );

    cache_data_store u_data (
        .cpu_intf      (cpu_intf),
        .addr          (haddr),
        .dwrite_en     (dwrite_en),
        .dwrite_offset (dwrite_offset),
        .wdata         (mem_rdata),
        .rdata         (hrdata)
    );

    mem_slave u_mem (
        .cpu_intf       (cpu_intf),
        .rst_n          (rst_n),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_beat_valid (mem_beat_valid),
        .mem_rdata      (mem_rdata)
    );

    // response is the hready cycle of the bus
    assign rsp_valid = hready;
    assign rsp_addr  = haddr;
    assign rsp_data  = hrdata;
    assign rsp_hit   = hit_flag;

endmodule

/* hw/cpu_req_gen.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module cpu_req_gen
    import cache_pkg::*;
(
    input  logic       cpu_intf,
    input  logic       rst_n,
    input  logic       run,
    input  logic [7:0] seed,
    input  count_t     period,
    input  count_t     req_count,
    input  logic       hready,
    output addr_t      haddr,
    output htrans_e    htrans,
    output hburst_e    hburst,
    output logic       done
);

    localparam int HP_W = $clog2(`HIST_DEPTH);

    logic              active;
    count_t            wait_cnt;
    count_t            remaining;
    count_t            reload;
    logic [7:0]        lfsr;
    logic [7:0]        lfsr_next;
    logic [HP_W:0]     hist_cnt;
    logic [HP_W-1:0]   hist_wr_ptr;
    logic [HP_W-1:0]   pick;
    addr_t             hist [`HIST_DEPTH];
    logic              reuse;
    logic              issue;
    addr_t             next_addr;

    assign hburst    = SINGLE;
    assign reload    = (period > count_t'(1)) ? period - count_t'(1) : '0;
    assign lfsr_next = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};

    assign issue = active && !run && (htrans != NONSEQ) && (wait_cnt <= count_t'(1));
    assign reuse = lfsr[7] && (hist_cnt != '0);

    // *****************************************************************
    // address choice
    // *****************************************************************
    always_comb begin
        pick = lfsr[HP_W-1:0];
        if ({1'b0, pick} >= hist_cnt)
            pick = hist_wr_ptr - 1'b1;  // fall back to newest entry
        if (reuse)
            next_addr = hist[pick];
        else
            next_addr = addr_t'(`WIN_BASE) + addr_t'({lfsr[5:0], 2'b00});
    end

    always_ff @(posedge cpu_intf) begin
        if (issue) begin
            haddr <= next_addr;
            if (!reuse)
                hist[hist_wr_ptr] <= next_addr;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            active      <= 1'b0;
            htrans      <= IDLE;
            done        <= 1'b0;
            wait_cnt    <= '0;
            remaining   <= '0;
            lfsr        <= 8'h01;
            hist_cnt    <= '0;
            hist_wr_ptr <= '0;
        end else begin
            done <= 1'b0;
            if (run) begin
                active      <= (req_count != '0);
                done        <= (req_count == '0);
                remaining   <= req_count;
                wait_cnt    <= reload;
                lfsr        <= (seed == 8'h00) ? 8'hA5 : seed;  // all zero would lock
                hist_cnt    <= '0;
                hist_wr_ptr <= '0;
                htrans      <= IDLE;
            end else if (htrans == NONSEQ) begin
                if (hready) begin
                    htrans    <= IDLE;
                    remaining <= remaining - count_t'(1);
                    wait_cnt  <= reload;
                    if (remaining == count_t'(1)) begin
                        active <= 1'b0;
                        done   <= 1'b1;
                    end
                end
            end else if (issue) begin
                htrans <= NONSEQ;
                lfsr   <= lfsr_next;
                if (!reuse) begin
                    hist_wr_ptr <= hist_wr_ptr + 1'b1;
                    if (hist_cnt != (HP_W+1)'(`HIST_DEPTH))
                        hist_cnt <= hist_cnt + 1'b1;
                end
            end else if (active) begin
                wait_cnt <= wait_cnt - count_t'(1);
            end
        end
    end

endmodule

/* hw/mem_slave.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module mem_slave
    import cache_pkg::*;
(
    input  logic  cpu_intf,
    input  logic  rst_n,
    input  logic  load_en,
    input  addr_t load_addr,
    input  data_t load_data,
    input  logic  mem_req,
    input  addr_t mem_addr,
    output logic  mem_beat_valid,
    output data_t mem_rdata
);

    localparam int MW_W = $clog2(`MEM_WORDS);

    data_t            mem [`MEM_WORDS];
    logic [MW_W-1:0]  base_q;
    offset_t          beat_cnt;
    logic [7:0]       elapsed;      // cycles since last request or beat
    logic             busy;
    logic             start;
    logic             beat_fire;

    assign start     = mem_req && !busy;
    assign beat_fire = busy && (elapsed >= 8'(`MEM_WAIT));

    // *****************************************************************
    // storage, preload and burst read
    // *****************************************************************
    always_ff @(posedge cpu_intf) begin
        if (load_en)
            mem[load_addr[OFF_LSB +: MW_W]] <= load_data;
        if (start)
            base_q <= mem_addr[OFF_LSB +: MW_W];
        if (beat_fire)
            mem_rdata <= mem[base_q + MW_W'(beat_cnt)];
    end

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            busy           <= 1'b0;
            beat_cnt       <= '0;
            elapsed        <= '0;
            mem_beat_valid <= 1'b0;
        end else begin
            mem_beat_valid <= beat_fire;
            if (start) begin
                busy     <= 1'b1;
                beat_cnt <= '0;
                elapsed  <= 8'd1;
            end else if (beat_fire) begin
                elapsed  <= '0;
                beat_cnt <= beat_cnt + 1'b1;
                if (beat_cnt == offset_t'(`WORDS_PER_LINE - 1))
                    busy <= 1'b0;   // incr4 complete
            end else if (busy) begin
                elapsed <= elapsed + 8'd1;
            end
        end
    end

endmodule

/* include/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// *********************************************************************
// bus widths
// *********************************************************************
`define ADDR_W          32
`define DATA_W          32

// *********************************************************************
// cache geometry
// *********************************************************************
`define LINES           8
`define WORDS_PER_LINE  4

// request generator
`define HIST_DEPTH      8                   // recent addresses kept for reuse
`define WIN_BASE        32'h0000_0A00       // 256 byte request window

// *********************************************************************
// backing memory
// *********************************************************************
`define MEM_WORDS       1024
`define MEM_WAIT        2                   // idle cycles before each beat

`endif

/* tests/cache_checker.sv */
`timescale 1ns/1ps

module cache_checker
    import cache_pkg::*;
(
    input  logic    cpu_intf,
    input  logic    rst_n,
    input  addr_t   haddr,
    input  htrans_e htrans,
    input  logic    hready,
    input  logic    hit
);

    int      fail_count = 0;
    htrans_e htrans_q;
    logic    lookup_q;      // first cycle after a new request

    always_ff @(posedge cpu_intf) begin
        htrans_q <= htrans;
        lookup_q <= (htrans == NONSEQ) && (htrans_q != NONSEQ);
    end

    // *****************************************************************
    // cpu side bus rules
    // *****************************************************************
    assert property (@(posedge cpu_intf) disable iff (!rst_n)
        hready |=> !hready)
    else begin
        fail_count++;
        $error("hready stayed high for more than one cycle");
    end

    assert property (@(posedge cpu_intf) disable iff (!rst_n)
        (lookup_q && hit) |=> hready)
    else begin
        fail_count++;
        $error("hit did not respond two cycles after the request");
    end

    assert property (@(posedge cpu_intf) disable iff (!rst_n)
        (htrans == NONSEQ && !hready) |=> (htrans == NONSEQ && $stable(haddr)))
    else begin
        fail_count++;
        $error("request dropped or changed before hready");
    end

endmodule

bind cache_top cache_checker cache_checker_inst (
    .cpu_intf (cpu_intf),
    .rst_n    (rst_n),
    .haddr    (haddr),
    .htrans   (htrans),
    .hready   (hready),
    .hit      (hit)
);

/* tests/cache_stim.txt */
# M <address hex> <data hex>                          preload one memory word
# R <seed hex> <period> <req_count> <min hits>        one generator run
M 00000A68 DEADBEEF
M 00000AA4 0BADF00D
M 00000A20 12345678
M 00000A24 9ABCDEF0
M 00000A88 CAFEF00D
M 00000A14 55AA55AA
M 00000A50 A5A5A5A5
M 00000A48 76543210
R 5A 3 16 3
R 5A 1 16 7
R 17 4 12 0
M 00000A0C 11223344
M 00000A28 FEEDFACE
M 00000A94 0F0F0F0F
M 00000AFC 80000001
M 00000A00 00C0FFEE
R C3 0 24 1
R 00 5 10 1
R 21 2 0 0
M 00000A68 13579BDF
M 00000A2C 2468ACE0
R 5A 2 20 3

/* tests/cache_tb.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_tb
    import cache_pkg::*;
();

    logic       cpu_intf;
    logic       rst_n;
    logic       run;
    logic [7:0] seed;
    count_t     period;
    count_t     req_count;
    logic       load_en;
    addr_t      load_addr;
    data_t      load_data;
    logic       rsp_valid;
    addr_t      rsp_addr;
    data_t      rsp_data;
    logic       rsp_hit;
    logic       done;

    data_t      ref_mem [`MEM_WORDS];
    logic       model_valid [`LINES];
    tag_t       model_tag [`LINES];

    int         errors = 0;
    int         checks = 0;
    int         wd_cycles = 0;
    int         cycle_cnt = 0;
    int         last_rsp_cycle = 0;
    int         run_rsp = 0;
    int         run_hits = 0;
    logic       in_run = 1'b0;

    cache_top cache_top_inst (
        .cpu_intf  (cpu_intf),
        .rst_n     (rst_n),
        .run       (run),
        .seed      (seed),
        .period    (period),
        .req_count (req_count),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rsp_valid (rsp_valid),
        .rsp_addr  (rsp_addr),
        .rsp_data  (rsp_data),
        .rsp_hit   (rsp_hit),
        .done      (done)
    );

    initial begin
        cpu_intf = 1'b0;
        forever #4 cpu_intf = ~cpu_intf;
    end

    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge cpu_intf);
        $display("timeout: the run hung, done did not come within %0d cycles", wd_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic report_error(input string what);
        errors++;
        $display("Error %0t: %s", $time, what);
    endtask

    // mixes all address bits
    function automatic data_t pattern_word(input addr_t a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    endfunction

    task automatic clear_model();
        for (int i = 0; i < `LINES; i++)
            model_valid[i] = 1'b0;
    endtask

    // all tasks below start and end 1 ns after a rising edge
    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(posedge cpu_intf);
        #1;
        rst_n = 1'b1;
        clear_model();
    endtask

    task automatic load_word(input addr_t a, input data_t d);
        load_en          = 1'b1;
        load_addr        = a;
        load_data        = d;
        ref_mem[a[11:2]] = d;
        @(posedge cpu_intf);
        #1;
        load_en = 1'b0;
    endtask

    task automatic fill_window();
        addr_t a;
        for (int i = 0; i < 64; i++) begin
            a = `WIN_BASE + addr_t'(i * 4);
            load_word(a, pattern_word(a));
        end
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1)
            c = $fgetc(fd);
    endtask

    task automatic do_run(input logic [7:0] s, input count_t p, input count_t n, input int m);
        seed      = s;
        period    = p;
        req_count = n;
        run       = 1'b1;
        in_run    = 1'b1;
        run_rsp   = 0;
        run_hits  = 0;
        @(posedge cpu_intf);
        #1;
        run = 1'b0;
        while (done !== 1'b1)
            @(negedge cpu_intf);
        @(posedge cpu_intf);
        #1;
        in_run = 1'b0;
        checks += 2;
        assert (run_rsp == int'(n))
        else report_error($sformatf("run gave %0d responses, expected %0d", run_rsp, n));
        assert (run_hits >= m)
        else report_error($sformatf("run gave %0d hits, expected at least %0d", run_hits, m));
    endtask

    // *********************************************************************
    // response monitor and tag model
    // *********************************************************************
    always @(negedge cpu_intf) begin : monitor
        index_t idx;
        tag_t   tag;
        logic   exp_hit;
        data_t  exp_data;
        cycle_cnt++;
        if (rst_n && !in_run) begin
            checks++;
            assert (rsp_valid == 1'b0 && done == 1'b0)
            else report_error("response or done outside a run");
        end
        if (rst_n && rsp_valid) begin
            idx      = rsp_addr[6:4];
            tag      = rsp_addr[31:7];
            exp_data = ref_mem[rsp_addr[11:2]];
            exp_hit  = model_valid[idx] && (model_tag[idx] == tag);
            checks  += 3;
            assert (rsp_addr[1:0] == 2'b00 && rsp_addr >= `WIN_BASE
                    && rsp_addr < `WIN_BASE + 32'h100)
            else report_error($sformatf("address %h outside the window", rsp_addr));
            assert (rsp_data == exp_data)
            else report_error($sformatf("data at %h is %h, expected %h",
                                        rsp_addr, rsp_data, exp_data));
            assert (rsp_hit == exp_hit)
            else report_error($sformatf("hit at %h is %b, expected %b",
                                        rsp_addr, rsp_hit, exp_hit));
            if (run_rsp != 0) begin
                checks++;
                assert (cycle_cnt - last_rsp_cycle >= int'(period) + 2)
                else report_error($sformatf("responses only %0d cycles apart",
                                            cycle_cnt - last_rsp_cycle));
            end
            model_valid[idx] = 1'b1;        // line now filled
            model_tag[idx]   = tag;
            last_rsp_cycle   = cycle_cnt;
            run_rsp++;
            if (rsp_hit)
                run_hits++;
        end
    end

    // *********************************************************************
    // stim file sequencing
    // *********************************************************************
    initial begin
        int         fd;
        int         code;
        int         budget;
        logic [7:0] kind;
        addr_t      a;
        data_t      d;
        logic [7:0] s;
        count_t     p;
        count_t     n;
        int         m;
        logic       after_run;
        rst_n     = 1'b0;
        run       = 1'b0;
        seed      = '0;
        period    = '0;
        req_count = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        after_run = 1'b0;
        fd = $fopen("tests/cache_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stim file tests/cache_stim.txt");
        end else begin
            budget = 2000;                  // preload, resets and slack
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "M") begin
                    code = $fscanf(fd, "%h %h", a, d);
                end else if (kind == "R") begin
                    code = $fscanf(fd, "%h %d %d %d", s, p, n, m);
                    budget += int'(n) * (int'(p) + 4 * (`MEM_WAIT + 1) + 8);
                end else begin
                    skip_line(fd);
                end
            end
            wd_cycles = budget;
            $fclose(fd);
            fd = $fopen("tests/cache_stim.txt", "r");
            @(posedge cpu_intf);
            #1;
            apply_reset();
            fill_window();
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "M") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    assert (code == 2)
                    else begin
                        errors++;
                        $display("a preload line of the stim file could not be parsed");
                    end
                    if (after_run) begin    // new preload section
                        apply_reset();
                        after_run = 1'b0;
                    end
                    load_word(a, d);
                end else if (kind == "R") begin
                    code = $fscanf(fd, "%h %d %d %d", s, p, n, m);
                    assert (code == 4)
                    else begin
                        errors++;
                        $display("a run line of the stim file could not be parsed");
                    end
                    do_run(s, p, n, m);
                    after_run = 1'b1;
                end else begin
                    skip_line(fd);
                end
            end
            $fclose(fd);
        end
        // bus assertion failures from the bound checker
        errors += cache_top_inst.cache_checker_inst.fail_count;
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
